//--- build.f
+incdir+design
design/dbg_isa_pkg.sv
design/dbg_mon_pkg.sv
design/dbg_insn_decode.sv
design/dbg_cause_tracker.sv
design/dbg_pc_capture.sv
design/dbg_check_result.sv
design/dbg_monitor_top.sv
tb/tb_dbg_monitor.sv

//--- design/dbg_cause_tracker.sv
`timescale 1ns/1ps

module dbg_cause_tracker (
  input  logic                     cov_assert_if,
  input  logic                     rst_i,
  input  dbg_mon_pkg::stage_item_t item_i,
  output dbg_mon_pkg::dbg_cause_e  exp_cause_o,
  output logic                     first_dbg_o
);
  import dbg_mon_pkg::*;

  dbg_cause_e cause_q;
  dbg_cause_e cause_d;
  // Set by a cycle outside debug mode, cleared by the first debug retirement
  logic       armed_q;

  assign exp_cause_o = cause_q;

  // ------------------------------
  // Expected cause
  // ------------------------------

  always_comb begin
    cause_d = cause_q;
    if (!item_i.dbg.debug_mode) begin
      if (trig_hit(item_i)) begin
        cause_d = CAUSE_TRIGGER;
      end else if (ebreak_hit(item_i)) begin
        cause_d = CAUSE_EBREAK;
      end else if (item_i.debug_req) begin
        cause_d = CAUSE_HALTREQ;
      end else if (item_i.dbg.dcsr_step
                   && ((cause_q == CAUSE_NONE) || (cause_q == CAUSE_STEP))) begin
        // Step never overrides a stronger pending cause
        cause_d = CAUSE_STEP;
      end else begin
        cause_d = CAUSE_NONE;
      end
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      cause_q <= CAUSE_NONE;
    end else begin
      cause_q <= cause_d;
    end
  end

  // ------------------------------
  // First debug retirement
  // ------------------------------

  assign first_dbg_o = armed_q && item_i.dbg.debug_mode && item_i.cls.valid;

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      armed_q <= 1'b0;
    end else if (!item_i.dbg.debug_mode) begin
      armed_q <= 1'b1;
    end else if (item_i.cls.valid) begin
      armed_q <= 1'b0;
    end
  end

  a_cause_frozen_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    item_i.dbg.debug_mode |=> $stable(exp_cause_o)
  );

endmodule

//--- design/dbg_check_result.sv
`timescale 1ns/1ps
`include "dbg_consts.svh"

module dbg_check_result (
  input  logic                      cov_assert_if,
  input  logic                      rst_i,
  input  dbg_mon_pkg::stage_item_t  item_i,
  input  dbg_mon_pkg::dbg_cause_e   exp_cause_i,
  input  logic                      first_dbg_i,
  input  logic [`DBG_XLEN-1:0]      exp_dpc_i,
  input  logic [`DBG_XLEN-1:0]      exp_halt_pc_i,
  output dbg_mon_pkg::viol_t        viol_o,
  output logic [`DBG_ERRCNT_W-1:0]  err_count_o
);
  import dbg_mon_pkg::*;

  viol_t                  viol_d;
  logic [2:0]             n_flags;
  logic [`DBG_ERRCNT_W:0] cnt_sum;
  logic [`DBG_ERRCNT_W-1:0] cnt_d;

  // ------------------------------
  // Rules
  // ------------------------------

  always_comb begin
    viol_d = '0;
    // Entry checks apply to the first debug retirement only
    viol_d.cause_bad    = first_dbg_i && (item_i.dbg.dcsr_cause != exp_cause_i);
    viol_d.dpc_bad      = first_dbg_i && (item_i.dbg.dpc != exp_dpc_i);
    viol_d.halt_pc_bad  = first_dbg_i && (item_i.cls.pc != exp_halt_pc_i);
    // dret in M-mode must have been flagged illegal
    viol_d.dret_mmode   = item_i.cls.dret && !item_i.dbg.debug_mode
                       && !item_i.cls.illegal;
    // Interrupts are masked in debug mode
    viol_d.irq_in_debug = item_i.irq_ack && item_i.dbg.debug_mode;
  end

  // ------------------------------
  // Error counter
  // ------------------------------

  assign n_flags = 3'($countones(viol_d));
  assign cnt_sum = {1'b0, err_count_o} + {{(`DBG_ERRCNT_W-2){1'b0}}, n_flags};

  // Saturate at all ones
  assign cnt_d = cnt_sum[`DBG_ERRCNT_W] ? {`DBG_ERRCNT_W{1'b1}}
                                        : cnt_sum[`DBG_ERRCNT_W-1:0];

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      viol_o      <= '0;
      err_count_o <= '0;
    end else begin
      viol_o      <= viol_d;
      err_count_o <= cnt_d;
    end
  end

  a_count_monotonic: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    !$past(rst_i) |-> (err_count_o >= $past(err_count_o))
  );

endmodule

//--- design/dbg_consts.svh
`ifndef DBG_CONSTS_SVH
`define DBG_CONSTS_SVH

// ------------------------------
// Widths
// ------------------------------

// Data and address width of the core
`define DBG_XLEN 32

// Width of dcsr.cause
`define DBG_CAUSE_W 3

// Saturating error counter
`define DBG_ERRCNT_W 16

// ------------------------------
// Instruction encodings
// ------------------------------

`define DBG_EBREAK_OPC  32'h0010_0073
`define DBG_CEBREAK_OPC 32'h0000_9002
`define DBG_WFI_OPC     32'h1050_0073
`define DBG_DRET_OPC    32'h7B20_0073

// ------------------------------
// dcsr.cause codes
// ------------------------------

`define DBG_CAUSE_CODE_NONE    3'd0
`define DBG_CAUSE_CODE_EBREAK  3'd1
`define DBG_CAUSE_CODE_TRIGGER 3'd2
`define DBG_CAUSE_CODE_HALTREQ 3'd3
`define DBG_CAUSE_CODE_STEP    3'd4

`endif

//--- design/dbg_insn_decode.sv
`timescale 1ns/1ps
`include "dbg_consts.svh"

module dbg_insn_decode (
  input  logic                     cov_assert_if,
  input  logic                     rst_i,
  input  dbg_isa_pkg::wb_sample_t  wb_i,
  input  dbg_mon_pkg::core_dbg_t   core_i,
  input  logic                     debug_req_i,
  input  logic                     irq_ack_i,
  input  logic [`DBG_XLEN-1:0]     halt_addr_i,
  output dbg_mon_pkg::stage_item_t item_o
);
  import dbg_isa_pkg::*;
  import dbg_mon_pkg::*;

  localparam insn_word_u EBREAK_W  = `DBG_EBREAK_OPC;
  localparam insn_word_u CEBREAK_W = `DBG_CEBREAK_OPC;
  localparam insn_word_u WFI_W     = `DBG_WFI_OPC;
  localparam insn_word_u DRET_W    = `DBG_DRET_OPC;

  logic        clean_ret;
  logic        sys_zero;
  insn_class_t cls_d;
  stage_item_t item_d;

  // Retired without bus error and with the MPU passing it
  assign clean_ret = wb_i.valid && !wb_i.err && wb_i.mpu_ok;

  // All three SYSTEM instructions share opcode and zero operand fields
  assign sys_zero = (wb_i.insn.rv32.opcode == EBREAK_W.rv32.opcode)
                 && (wb_i.insn.rv32.funct3 == EBREAK_W.rv32.funct3)
                 && (wb_i.insn.rv32.rs1 == EBREAK_W.rv32.rs1)
                 && (wb_i.insn.rv32.rd == EBREAK_W.rv32.rd);

  // ------------------------------
  // Classification
  // ------------------------------

  always_comb begin
    cls_d         = '0;
    cls_d.valid   = wb_i.valid;
    cls_d.pc      = wb_i.pc;
    cls_d.next_pc = wb_i.next_pc;
    cls_d.illegal = wb_i.illegal;
    cls_d.ebreak  = clean_ret && sys_zero
                 && (wb_i.insn.rv32.funct12 == EBREAK_W.rv32.funct12);
    cls_d.wfi     = clean_ret && sys_zero
                 && (wb_i.insn.rv32.funct12 == WFI_W.rv32.funct12);
    cls_d.dret    = clean_ret && sys_zero
                 && (wb_i.insn.rv32.funct12 == DRET_W.rv32.funct12);
    // Compressed form only counts with a zero upper halfword
    cls_d.cebreak = clean_ret && (wb_i.insn.rvc.upper == '0)
                 && (wb_i.insn.rvc.cinsn == CEBREAK_W.rvc.cinsn);
  end

  always_comb begin
    item_d           = '0;
    item_d.cls       = cls_d;
    item_d.dbg       = core_i;
    item_d.debug_req = debug_req_i;
    item_d.irq_ack   = irq_ack_i;
    item_d.halt_addr = halt_addr_i;
  end

  // Whole snapshot moves together, only the control bits are cleared
  always_ff @(posedge cov_assert_if) begin
    item_o <= item_d;
    if (rst_i) begin
      item_o.cls.valid      <= 1'b0;
      item_o.cls.ebreak     <= 1'b0;
      item_o.cls.cebreak    <= 1'b0;
      item_o.cls.wfi        <= 1'b0;
      item_o.cls.dret       <= 1'b0;
      item_o.debug_req      <= 1'b0;
      item_o.irq_ack        <= 1'b0;
      item_o.dbg.debug_mode <= 1'b0;
    end
  end

  a_kind_onehot0: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    wb_i.valid |=> $onehot0({item_o.cls.ebreak, item_o.cls.cebreak,
                             item_o.cls.wfi, item_o.cls.dret})
  );

endmodule

//--- design/dbg_isa_pkg.sv
`include "dbg_consts.svh"

package dbg_isa_pkg;

  // ------------------------------
  // Instruction word views
  // ------------------------------

  // Base 32-bit encoding, SYSTEM layout
  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv32_insn_t;

  // Compressed encoding sits in the low halfword
  typedef struct packed {
    logic [15:0] upper;
    logic [15:0] cinsn;
  } rvc_insn_t;

  typedef union packed {
    rv32_insn_t rv32;
    rvc_insn_t  rvc;
  } insn_word_u;

  // One retirement as seen in the WB stage
  typedef struct packed {
    logic                 valid;
    insn_word_u           insn;
    logic [`DBG_XLEN-1:0] pc;
    logic [`DBG_XLEN-1:0] next_pc;
    logic                 err;
    logic                 mpu_ok;
    logic                 illegal;
  } wb_sample_t;

  // Classified retirement, at most one kind flag is set
  typedef struct packed {
    logic                 valid;
    logic [`DBG_XLEN-1:0] pc;
    logic [`DBG_XLEN-1:0] next_pc;
    logic                 illegal;
    logic                 ebreak;
    logic                 cebreak;
    logic                 wfi;
    logic                 dret;
  } insn_class_t;

endpackage

//--- design/dbg_mon_pkg.sv
`include "dbg_consts.svh"

package dbg_mon_pkg;

  // Debug view of the core, sampled with each retirement
  typedef struct packed {
    logic                    debug_mode;
    logic [`DBG_CAUSE_W-1:0] dcsr_cause;
    logic                    dcsr_step;
    logic                    dcsr_ebreakm;
    // tdata1 execute enable
    logic                    trig_en;
    logic [`DBG_XLEN-1:0]    tdata2;
    logic [`DBG_XLEN-1:0]    dpc;
  } core_dbg_t;

  typedef enum logic [`DBG_CAUSE_W-1:0] {
    CAUSE_NONE    = `DBG_CAUSE_CODE_NONE,
    CAUSE_EBREAK  = `DBG_CAUSE_CODE_EBREAK,
    CAUSE_TRIGGER = `DBG_CAUSE_CODE_TRIGGER,
    CAUSE_HALTREQ = `DBG_CAUSE_CODE_HALTREQ,
    CAUSE_STEP    = `DBG_CAUSE_CODE_STEP
  } dbg_cause_e;

  // Snapshot handed from decode to the later stages
  typedef struct packed {
    dbg_isa_pkg::insn_class_t cls;
    core_dbg_t                dbg;
    logic                     debug_req;
    logic                     irq_ack;
    logic [`DBG_XLEN-1:0]     halt_addr;
  } stage_item_t;

  typedef struct packed {
    logic cause_bad;
    logic dpc_bad;
    logic halt_pc_bad;
    logic dret_mmode;
    logic irq_in_debug;
  } viol_t;

  // ------------------------------
  // Entry conditions
  // ------------------------------

  // Execute trigger on the retiring pc
  function automatic logic trig_hit(stage_item_t it);
    return it.cls.valid && it.dbg.trig_en && (it.cls.pc == it.dbg.tdata2);
  endfunction

  // ebreak or c.ebreak that enters debug instead of trapping
  function automatic logic ebreak_hit(stage_item_t it);
    return (it.cls.ebreak || it.cls.cebreak) && it.dbg.dcsr_ebreakm;
  endfunction

endpackage

//--- design/dbg_monitor_top.sv
`timescale 1ns/1ps
`include "dbg_consts.svh"

module dbg_monitor_top (
  input  logic                     cov_assert_if,
  input  logic                     rst_i,
  input  dbg_isa_pkg::wb_sample_t  wb_i,
  input  dbg_mon_pkg::core_dbg_t   core_i,
  input  logic                     debug_req_i,
  input  logic                     irq_ack_i,
  input  logic [`DBG_XLEN-1:0]     halt_addr_i,
  output dbg_mon_pkg::viol_t       viol_o,
  output logic [`DBG_ERRCNT_W-1:0] err_count_o
);
  import dbg_mon_pkg::*;

  stage_item_t          item;
  dbg_cause_e           exp_cause;
  logic                 first_dbg;
  logic [`DBG_XLEN-1:0] exp_dpc;
  logic [`DBG_XLEN-1:0] exp_halt_pc;

  // ------------------------------
  // Decode stage
  // ------------------------------

  dbg_insn_decode u_decode (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .wb_i          (wb_i),
    .core_i        (core_i),
    .debug_req_i   (debug_req_i),
    .irq_ack_i     (irq_ack_i),
    .halt_addr_i   (halt_addr_i),
    .item_o        (item)
  );

  // ------------------------------
  // Execute stage
  // ------------------------------

  dbg_cause_tracker u_cause (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .item_i        (item),
    .exp_cause_o   (exp_cause),
    .first_dbg_o   (first_dbg)
  );

  dbg_pc_capture u_pc (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .item_i        (item),
    .exp_dpc_o     (exp_dpc),
    .exp_halt_pc_o (exp_halt_pc)
  );

  // Result stage
  dbg_check_result u_result (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .item_i        (item),
    .exp_cause_i   (exp_cause),
    .first_dbg_i   (first_dbg),
    .exp_dpc_i     (exp_dpc),
    .exp_halt_pc_i (exp_halt_pc),
    .viol_o        (viol_o),
    .err_count_o   (err_count_o)
  );

endmodule

//--- design/dbg_pc_capture.sv
`timescale 1ns/1ps
`include "dbg_consts.svh"

module dbg_pc_capture (
  input  logic                     cov_assert_if,
  input  logic                     rst_i,
  input  dbg_mon_pkg::stage_item_t item_i,
  output logic [`DBG_XLEN-1:0]     exp_dpc_o,
  output logic [`DBG_XLEN-1:0]     exp_halt_pc_o
);
  import dbg_mon_pkg::*;

  logic                 dmode_q;
  logic                 dpc_upd;
  logic [`DBG_XLEN-1:0] dpc_d;

  // Only retirements outside debug mode move the prediction
  assign dpc_upd = item_i.cls.valid && !item_i.dbg.debug_mode;

  // Trigger and ebreak entries do not retire past the instruction
  assign dpc_d = (trig_hit(item_i) || ebreak_hit(item_i)) ? item_i.cls.pc
                                                          : item_i.cls.next_pc;

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      dmode_q <= 1'b0;
    end else begin
      dmode_q <= item_i.dbg.debug_mode;
    end
  end

  // ------------------------------
  // Prediction registers
  // ------------------------------

  always_ff @(posedge cov_assert_if) begin
    if (dpc_upd) begin
      exp_dpc_o <= dpc_d;
    end
    // Follows the halt address while running, last load is the entry cycle
    if (!dmode_q) begin
      exp_halt_pc_o <= {item_i.halt_addr[`DBG_XLEN-1:2], 2'b00};
    end
  end

  a_dpc_frozen_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    item_i.dbg.debug_mode |=> $stable(exp_dpc_o)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the debug monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_dbg_monitor -o sim_tb_dbg_monitor \
  && ./obj_dir/sim_tb_dbg_monitor | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }

//--- tb/tb_dbg_monitor.sv
`timescale 1ns/1ps
`include "dbg_consts.svh"

module tb_dbg_monitor;
  import dbg_isa_pkg::*;
  import dbg_mon_pkg::*;

  localparam int NROWS   = 14;
  localparam int TIMEOUT = 64;

  // One scenario: entry retirement, optional debug retirement, expected result
  typedef struct packed {
    logic [31:0] insn;
    logic        debug_req;
    logic        step;
    logic        ebreakm;
    logic        trig;
    logic        illegal;
    logic        has_dbg;
    logic [2:0]  rep_cause;
    // 0 next_pc, 1 own pc, 2 wrong value
    logic [1:0]  dpc_sel;
    logic        pc_bad;
    logic        irq_ack;
    logic [31:0] halt_addr;
    viol_t       exp_viol;
    logic [2:0]  inc;
  } row_t;

  logic                     cov_assert_if;
  logic                     rst_i;
  wb_sample_t               wb;
  core_dbg_t                core;
  logic                     debug_req;
  logic                     irq_ack;
  logic [`DBG_XLEN-1:0]     halt_addr;
  viol_t                    viol_o;
  logic [`DBG_ERRCNT_W-1:0] err_count_o;

  row_t  table_q [NROWS];
  string names [NROWS];
  int    seed = 50703;
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    exp_total = 0;
  logic  timed_out = 1'b0;

  dbg_monitor_top uut (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .wb_i          (wb),
    .core_i        (core),
    .debug_req_i   (debug_req),
    .irq_ack_i     (irq_ack),
    .halt_addr_i   (halt_addr),
    .viol_o        (viol_o),
    .err_count_o   (err_count_o)
  );

  always #10 cov_assert_if = ~cov_assert_if;

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  function automatic row_t make_row(logic [31:0] insn, logic dreq, logic step, logic ebm,
                                    logic trig, logic ill, logic has_dbg, logic [2:0] cause,
                                    logic [1:0] dsel, logic pc_bad, logic irq,
                                    logic [31:0] haddr, logic [4:0] viol, logic [2:0] inc);
    row_t r;
    r.insn      = insn;
    r.debug_req = dreq;
    r.step      = step;
    r.ebreakm   = ebm;
    r.trig      = trig;
    r.illegal   = ill;
    r.has_dbg   = has_dbg;
    r.rep_cause = cause;
    r.dpc_sel   = dsel;
    r.pc_bad    = pc_bad;
    r.irq_ack   = irq;
    r.halt_addr = haddr;
    r.exp_viol  = viol;
    r.inc       = inc;
    return r;
  endfunction

  // Viol bit order: cause, dpc, halt pc, dret, irq
  task automatic init_table();
    table_q[0]  = make_row(32'h0000_0013, 1, 0, 0, 0, 0, 1, 3'd3, 0, 0, 0, 32'h0000_0803,
                           5'b00000, 0);
    names[0]    = "haltreq entry";
    table_q[1]  = make_row(32'h0000_0013, 1, 0, 0, 0, 0, 1, 3'd4, 0, 0, 0, 32'h0000_0803,
                           5'b10000, 1);
    names[1]    = "haltreq wrong cause";
    table_q[2]  = make_row(`DBG_EBREAK_OPC, 0, 0, 1, 0, 0, 1, 3'd1, 1, 0, 0, 32'h0000_1a02,
                           5'b00000, 0);
    names[2]    = "ebreak entry";
    table_q[3]  = make_row(`DBG_CEBREAK_OPC, 0, 0, 1, 0, 0, 1, 3'd1, 1, 0, 0, 32'h0000_1a00,
                           5'b00000, 0);
    names[3]    = "c.ebreak entry";
    table_q[4]  = make_row(`DBG_EBREAK_OPC, 0, 0, 1, 0, 0, 1, 3'd1, 0, 0, 0, 32'h0000_1a00,
                           5'b01000, 1);
    names[4]    = "ebreak wrong dpc";
    table_q[5]  = make_row(32'h0000_0013, 1, 0, 0, 1, 0, 1, 3'd2, 1, 0, 0, 32'h0000_0801,
                           5'b00000, 0);
    names[5]    = "trigger beats haltreq";
    table_q[6]  = make_row(32'h0000_0013, 1, 0, 0, 1, 0, 1, 3'd2, 1, 1, 0, 32'h0000_0801,
                           5'b00100, 1);
    names[6]    = "trigger wrong halt pc";
    table_q[7]  = make_row(32'h0000_0013, 0, 1, 0, 0, 0, 1, 3'd4, 0, 0, 0, 32'h0000_0800,
                           5'b00000, 0);
    names[7]    = "single step entry";
    table_q[8]  = make_row(`DBG_WFI_OPC, 0, 0, 0, 0, 0, 0, 3'd0, 0, 0, 0, 32'h0000_0800,
                           5'b00000, 0);
    names[8]    = "wfi without step";
    table_q[9]  = make_row(32'h0000_0013, 0, 0, 0, 0, 0, 0, 3'd0, 0, 0, 0, 32'h0000_0800,
                           5'b00000, 0);
    names[9]    = "plain retirement";
    table_q[10] = make_row(`DBG_DRET_OPC, 0, 0, 0, 0, 0, 0, 3'd0, 0, 0, 0, 32'h0000_0800,
                           5'b00010, 1);
    names[10]   = "dret outside debug";
    table_q[11] = make_row(`DBG_DRET_OPC, 0, 0, 0, 0, 1, 0, 3'd0, 0, 0, 0, 32'h0000_0800,
                           5'b00000, 0);
    names[11]   = "illegal dret";
    table_q[12] = make_row(32'h0000_0013, 1, 0, 0, 0, 0, 1, 3'd3, 0, 0, 1, 32'h0000_0800,
                           5'b00001, 1);
    names[12]   = "irq ack in debug";
    table_q[13] = make_row(32'h0000_0013, 1, 0, 0, 0, 0, 1, 3'd1, 2, 1, 0, 32'h0000_0c03,
                           5'b11100, 3);
    names[13]   = "three entry faults";
  endtask

  task automatic drive_idle();
    wb        <= '0;
    core      <= '0;
    debug_req <= 1'b0;
    irq_ack   <= 1'b0;
  endtask

  // OR together the pulses seen over a window of cycles
  task automatic collect_viol(input int ncyc, output viol_t acc);
    int n;
    int guard;
    acc   = '0;
    n     = 0;
    guard = 0;
    while (n < ncyc && !timed_out) begin
      @(negedge cov_assert_if);
      acc   = acc | viol_o;
      n     = n + 1;
      guard = guard + 1;
      if (guard > TIMEOUT) begin
        $display("timeout while waiting for monitor results");
        timed_out = 1'b1;
      end
    end
  endtask

  // ------------------------------
  // Scenario
  // ------------------------------

  task automatic run_row(input int idx);
    row_t        r;
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] dpc_rep;
    logic [31:0] pc_rep;
    wb_sample_t  s;
    core_dbg_t   c;
    viol_t       acc;
    int          err_before;
    r          = table_q[idx];
    err_before = errors;
    pc         = $random(seed);
    pc         = {pc[31:2], 2'b00};
    npc        = (r.insn == `DBG_CEBREAK_OPC) ? pc + 32'd2 : pc + 32'd4;
    case (r.dpc_sel)
      2'd0:    dpc_rep = npc;
      2'd1:    dpc_rep = pc;
      default: dpc_rep = pc + 32'h100;
    endcase
    pc_rep = {r.halt_addr[31:2], 2'b00} + (r.pc_bad ? 32'd4 : 32'd0);

    s              = '0;
    s.valid        = 1'b1;
    s.insn         = r.insn;
    s.pc           = pc;
    s.next_pc      = npc;
    s.mpu_ok       = 1'b1;
    s.illegal      = r.illegal;
    c              = '0;
    c.dcsr_step    = r.step;
    c.dcsr_ebreakm = r.ebreakm;
    c.trig_en      = r.trig;
    c.tdata2       = r.trig ? pc : 32'h0;

    @(posedge cov_assert_if);
    wb        <= s;
    core      <= c;
    debug_req <= r.debug_req;
    irq_ack   <= 1'b0;
    halt_addr <= r.halt_addr;

    @(posedge cov_assert_if);
    if (r.has_dbg) begin
      s              = '0;
      s.valid        = 1'b1;
      s.insn         = 32'h0000_0013;
      s.pc           = pc_rep;
      s.next_pc      = pc_rep + 32'd4;
      s.mpu_ok       = 1'b1;
      c              = '0;
      c.debug_mode   = 1'b1;
      c.dcsr_cause   = r.rep_cause;
      c.dpc          = dpc_rep;
      wb        <= s;
      core      <= c;
      debug_req <= 1'b0;
      irq_ack   <= r.irq_ack;
    end else begin
      drive_idle();
    end

    @(posedge cov_assert_if);
    drive_idle();

    collect_viol(r.has_dbg ? 4 : 2, acc);
    exp_total = exp_total + r.inc;
    check_val("viol_o", 32'(acc), 32'(r.exp_viol));
    check_val("err_count_o", 32'(err_count_o), 32'(exp_total));

    tests_run = tests_run + 1;
    if (errors != err_before || timed_out) begin
      tests_failed = tests_failed + 1;
    end
    $display("test %0d %s: %s", idx + 1, names[idx],
             (errors == err_before && !timed_out) ? "ok" : "failed");
  endtask

  initial begin
    int n;
    cov_assert_if = 1'b0;
    rst_i         = 1'b1;
    wb            = '0;
    core          = '0;
    debug_req     = 1'b0;
    irq_ack       = 1'b0;
    halt_addr     = '0;
    init_table();

    // Reset held for 16 cycles
    n = 0;
    while (n < 16 && n < TIMEOUT) begin
      @(posedge cov_assert_if);
      n = n + 1;
    end
    rst_i <= 1'b0;
    @(negedge cov_assert_if);
    check_val("viol_o", 32'(viol_o), 32'h0);
    check_val("err_count_o", 32'(err_count_o), 32'h0);
    tests_run = tests_run + 1;
    if (errors != 0) begin
      tests_failed = tests_failed + 1;
    end
    $display("test 0 reset values: %s", (errors == 0) ? "ok" : "failed");

    for (int i = 0; i < NROWS && !timed_out; i++) begin
      run_row(i);
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
